//--- design/icache_pkg.sv
// icache package with cache geometry, address and block types, and FSM state encodings
`default_nettype none

package icache_pkg;

	////////////////////
	// geometry
	////////////////////

	// two fetch ways share one cache
	localparam int NUM_WAYS = 2;

	// 8 bytes per block
	localparam int OFFSET_BITS = 3;
	localparam int INDEX_BITS = 5;
	localparam int TAG_BITS = 8;

	// direct mapped, one line per index
	localparam int NUM_LINES = 1 << INDEX_BITS;

	////////////////////
	// types
	////////////////////

	// byte address of a fetch, tag above index above offset
	typedef logic [TAG_BITS+INDEX_BITS+OFFSET_BITS-1:0] fetch_addr_t;

	// block address as carried on the bus
	typedef logic [TAG_BITS+INDEX_BITS-1:0] line_addr_t;

	typedef logic [INDEX_BITS-1:0] cache_index_t;
	typedef logic [TAG_BITS-1:0] cache_tag_t;

	// one cache block, same width as bus data
	typedef logic [63:0] block_t;

	// per-way miss handler
	typedef enum logic {
		MISS_IDLE,
		MISS_BUS
	} miss_state_t;

	// shared bus owner FSM
	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

endpackage

`default_nettype wire

//--- design/icache_mem.sv
// direct-mapped instruction cache storage with two tag-checked read ports and one refill port
`default_nettype none

module icache_mem import icache_pkg::*; (
	input logic clock,
	input logic rst_n,

	// refill write port
	input logic wr_en,
	input cache_index_t wr_index,
	input cache_tag_t wr_tag,
	input block_t wr_data,

	// fetch read ports
	input fetch_addr_t rd_addr_0,
	input fetch_addr_t rd_addr_1,
	output block_t rd_data_0,
	output block_t rd_data_1,
	output logic [NUM_WAYS-1:0] rd_valid
);

	// line storage
	block_t lines [NUM_LINES];
	cache_tag_t tags [NUM_LINES];
	logic [NUM_LINES-1:0] valid;

	// read ports gathered for the per-way lookup
	fetch_addr_t port_addr [NUM_WAYS];
	block_t port_data [NUM_WAYS];

	assign port_addr[0] = rd_addr_0;
	assign port_addr[1] = rd_addr_1;
	assign rd_data_0 = port_data[0];
	assign rd_data_1 = port_data[1];

	////////////////////
	// lookup
	////////////////////

	for (genvar i = 0; i < NUM_WAYS; i++) begin : g_port
		cache_index_t rd_index;
		cache_tag_t rd_tag;

		// split byte address, offset bits are ignored
		assign rd_index = port_addr[i][OFFSET_BITS +: INDEX_BITS];
		assign rd_tag = port_addr[i][OFFSET_BITS+INDEX_BITS +: TAG_BITS];

		// combinational, hit shows in the same cycle
		assign port_data[i] = lines[rd_index];
		assign rd_valid[i] = valid[rd_index] && (tags[rd_index] == rd_tag);
	end

	////////////////////
	// refill
	////////////////////

	// block and tag, overwritten on every refill
	always_ff @(posedge clock) begin
		if (wr_en) begin
			lines[wr_index] <= wr_data;
			tags[wr_index] <= wr_tag;
		end
	end

	// valid bits
	// a refill evicts whatever line held this index
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (wr_en) begin
			valid[wr_index] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/miss_handler.sv
// per-way miss handler that latches a missing block address and requests its refill
`default_nettype none

module miss_handler import icache_pkg::*; (
	input logic clock,
	input logic rst_n,

	// fetch side
	input logic en,
	input fetch_addr_t addr,
	input logic hit,

	// arbiter side
	input logic ack,
	output logic req,
	output line_addr_t req_adr
);

	miss_state_t state;
	logic miss;

	// only an enabled fetch can start a refill
	assign miss = en && !hit;

	////////////////////
	// state
	////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= MISS_IDLE;
		end else begin
			case (state)
				MISS_IDLE: begin
					if (miss) begin
						state <= MISS_BUS;
					end
				end
				MISS_BUS: begin
					// stay until the owner ack, fetch address may have moved on
					if (ack) begin
						state <= MISS_IDLE;
					end
				end
				default: begin
					state <= MISS_IDLE;
				end
			endcase
		end
	end

	// block address, captured once per miss
	// frozen while the request is outstanding
	always_ff @(posedge clock) begin
		if (state == MISS_IDLE && miss) begin
			req_adr <= addr[OFFSET_BITS +: TAG_BITS+INDEX_BITS];
		end
	end

	// request held for the whole bus phase
	assign req = (state == MISS_BUS);

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
// round-robin owner of the shared Wishbone classic read bus for the two miss handlers
`default_nettype none

module bus_arbiter import icache_pkg::*; (
	input logic clock,
	input logic rst_n,

	// miss handlers
	input logic [NUM_WAYS-1:0] req,
	input line_addr_t req_adr_0,
	input line_addr_t req_adr_1,
	output logic [NUM_WAYS-1:0] grant_ack,

	// wishbone master
	output logic wb_cyc,
	output logic wb_stb,
	output line_addr_t wb_adr,
	input logic wb_ack
);

	arb_state_t state;

	// way that wins a tie
	logic prio;
	logic owner;

	// choice for the next transfer
	logic pick;
	line_addr_t pick_adr;

	////////////////////
	// selection
	////////////////////

	// a lone requester wins regardless of priority
	always_comb begin
		if (req[prio]) begin
			pick = prio;
		end else begin
			pick = !prio;
		end
	end

	assign pick_adr = pick ? req_adr_1 : req_adr_0;

	////////////////////
	// ownership
	////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			prio <= 1'b0;
			owner <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (|req) begin
						owner <= pick;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					// the other way gets first pick next time
					if (wb_ack) begin
						prio <= !owner;
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// address stays put until ack
	always_ff @(posedge clock) begin
		if (state == ARB_IDLE && |req) begin
			wb_adr <= pick_adr;
		end
	end

	// cyc and stb move together, low in the cycle after ack
	assign wb_cyc = (state == ARB_BUSY);
	assign wb_stb = (state == ARB_BUSY);

	// ack routed only to the current owner
	always_comb begin
		grant_ack = '0;
		if (state == ARB_BUSY && wb_ack) begin
			grant_ack[owner] = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/icache_top.sv
// instruction cache top with two fetch ways, per-way miss handlers and a shared refill bus
`default_nettype none

module icache_top import icache_pkg::*; (
	input logic clock,
	input logic rst_n,

	// fetch ways
	input fetch_addr_t fetch_addr_0,
	input fetch_addr_t fetch_addr_1,
	input logic [NUM_WAYS-1:0] fetch_en,
	output block_t fetch_data_0,
	output block_t fetch_data_1,
	output logic [NUM_WAYS-1:0] fetch_valid,

	// wishbone classic, read only
	output logic wb_cyc,
	output logic wb_stb,
	output line_addr_t wb_adr,
	input block_t wb_dat_i,
	input logic wb_ack
);

	// handler to arbiter
	logic [NUM_WAYS-1:0] req;
	logic [NUM_WAYS-1:0] grant_ack;
	line_addr_t req_adr_0;
	line_addr_t req_adr_1;

	// refill target, taken straight off the bus address
	cache_index_t refill_index;
	cache_tag_t refill_tag;

	assign refill_index = wb_adr[INDEX_BITS-1:0];
	assign refill_tag = wb_adr[INDEX_BITS +: TAG_BITS];

	////////////////////
	// storage
	////////////////////

	// every bus ack is a refill write
	icache_mem mem0 (
		.clock(clock),
		.rst_n(rst_n),
		.wr_en(wb_ack),
		.wr_index(refill_index),
		.wr_tag(refill_tag),
		.wr_data(wb_dat_i),
		.rd_addr_0(fetch_addr_0),
		.rd_addr_1(fetch_addr_1),
		.rd_data_0(fetch_data_0),
		.rd_data_1(fetch_data_1),
		.rd_valid(fetch_valid)
	);

	////////////////////
	// miss handling
	////////////////////

	// hit of each way feeds its own handler
	miss_handler miss0 (
		.clock(clock),
		.rst_n(rst_n),
		.en(fetch_en[0]),
		.addr(fetch_addr_0),
		.hit(fetch_valid[0]),
		.ack(grant_ack[0]),
		.req(req[0]),
		.req_adr(req_adr_0)
	);

	miss_handler miss1 (
		.clock(clock),
		.rst_n(rst_n),
		.en(fetch_en[1]),
		.addr(fetch_addr_1),
		.hit(fetch_valid[1]),
		.ack(grant_ack[1]),
		.req(req[1]),
		.req_adr(req_adr_1)
	);

	// one transfer at a time on the memory bus
	bus_arbiter arb0 (
		.clock(clock),
		.rst_n(rst_n),
		.req(req),
		.req_adr_0(req_adr_0),
		.req_adr_1(req_adr_1),
		.grant_ack(grant_ack),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

//--- bench/icache_props.sv
// Wishbone protocol and returned-data properties of the instruction cache top
`default_nettype none

module icache_props import icache_pkg::*; (
	input logic clock,
	input logic rst_n,
	input fetch_addr_t fetch_addr_0,
	input fetch_addr_t fetch_addr_1,
	input logic [NUM_WAYS-1:0] fetch_en,
	input block_t fetch_data_0,
	input block_t fetch_data_1,
	input logic [NUM_WAYS-1:0] fetch_valid,
	input logic [NUM_WAYS-1:0] req,
	input logic wb_cyc,
	input logic wb_stb,
	input line_addr_t wb_adr,
	input logic wb_ack
);

	// violations so far
	int unsigned fail_count = 0;

	// memory contents for a block address
	function automatic block_t expected_block(input line_addr_t adr);
		logic [31:0] low;
		low = 32'(adr);
		return {~low, low};
	endfunction

	////////////////////
	// bus protocol
	////////////////////

	a_reset_clear: assert property (@(posedge clock) !rst_n |=> !wb_cyc && fetch_valid == '0)
	else begin
		fail_count++;
		$error("bus or valid bits not clear after reset");
	end

	// held until the slave answers
	a_hold: assert property (@(posedge clock) disable iff (!rst_n)
		wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
	else begin
		fail_count++;
		$error("cyc, stb or address moved while waiting for ack");
	end

	a_drop: assert property (@(posedge clock) disable iff (!rst_n)
		wb_cyc && wb_ack |=> !wb_cyc && !wb_stb)
	else begin
		fail_count++;
		$error("cyc or stb still high in the cycle after ack");
	end

	a_ack_in_cycle: assert property (@(posedge clock) disable iff (!rst_n) wb_ack |-> wb_cyc)
	else begin
		fail_count++;
		$error("ack outside a bus cycle");
	end

	// a disabled way never asks for the bus
	for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
		a_req_needs_en: assert property (@(posedge clock) disable iff (!rst_n)
			$rose(req[i]) |-> $past(fetch_en[i]))
		else begin
			fail_count++;
			$error("way %0d requested a refill while disabled", i);
		end
	end

	////////////////////
	// returned data
	////////////////////

	a_data_0: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_valid[0] |-> fetch_data_0 == expected_block(line_addr_t'(fetch_addr_0 >> OFFSET_BITS)))
	else begin
		fail_count++;
		$error("way 0 hit shows the wrong block");
	end

	a_data_1: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_valid[1] |-> fetch_data_1 == expected_block(line_addr_t'(fetch_addr_1 >> OFFSET_BITS)))
	else begin
		fail_count++;
		$error("way 1 hit shows the wrong block");
	end

endmodule

bind icache_top icache_props props0 (.*);

`default_nettype wire

//--- bench/icache_tb.sv
// testbench for the instruction cache, two fetch ways against a random-latency Wishbone memory
`default_nettype none

module icache_tb import icache_pkg::*; ();

	// about four times the stimulus length at the longest ack delay
	localparam int CYCLE_LIMIT = 2000;

	logic clock;
	logic rst_n;
	fetch_addr_t fetch_addr_0;
	fetch_addr_t fetch_addr_1;
	logic [NUM_WAYS-1:0] fetch_en;
	block_t fetch_data_0;
	block_t fetch_data_1;
	logic [NUM_WAYS-1:0] fetch_valid;
	logic wb_cyc;
	logic wb_stb;
	line_addr_t wb_adr;
	block_t wb_dat_i = '0;
	logic wb_ack = 1'b0;

	// memory model state
	integer seed = 4975;
	int ack_wait = -1;
	int xfer_count = 0;
	int cycles = 0;
	logic [31:0] r;

	icache_top dut0 (.*);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	////////////////////
	// memory model
	////////////////////

	// ack after 0 to 3 extra cycles, data follows the address
	always @(posedge clock) begin
		int delay;
		if (!rst_n) begin
			wb_ack <= 1'b0;
			ack_wait <= -1;
		end else if (wb_ack) begin
			// single-cycle ack
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (ack_wait < 0) begin
				delay = $random(seed) & 3;
			end else begin
				delay = ack_wait;
			end
			if (delay == 0) begin
				wb_ack <= 1'b1;
				// upper half is the inverted address
				wb_dat_i <= {~{19'd0, wb_adr}, {19'd0, wb_adr}};
				ack_wait <= -1;
			end else begin
				ack_wait <= delay - 1;
			end
		end
	end

	// finished transfers seen on the bus
	always @(posedge clock) begin
		if (rst_n && wb_ack) begin
			xfer_count <= xfer_count + 1;
		end
	end

	// run limit and property watch
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped, no progress after %0d cycles", cycles);
			$display("sim failed");
			$fatal(1);
		end else if (dut0.props0.fail_count != 0) begin
			$display("a bus or data property of the cache was violated");
			$display("sim failed");
			$fatal(1);
		end
	end

	////////////////////
	// helpers
	////////////////////

	// drive on the rising edge, return at the falling edge
	task automatic present(input fetch_addr_t a0, input fetch_addr_t a1, input logic [1:0] en);
		@(posedge clock);
		fetch_addr_0 <= a0;
		fetch_addr_1 <= a1;
		fetch_en <= en;
		@(negedge clock);
	endtask

	task automatic wait_valid(input logic [1:0] mask);
		while ((fetch_valid & mask) != mask) @(negedge clock);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("Fail %s expected %0d actual %0d", name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		fetch_addr_0 = '0;
		fetch_addr_1 = '0;
		fetch_en = '0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;

		// nothing cached, bus idle
		present(16'h1238, 16'h2450, 2'b00);
		check_value("reset_valid", 0, int'(fetch_valid));
		check_value("reset_cyc", 0, int'(wb_cyc));

		// cold miss on way 0
		present(16'h1238, 16'h2450, 2'b01);
		check_value("cold_miss", 0, int'(fetch_valid[0]));
		while (!wb_cyc) @(negedge clock);
		wait_valid(2'b01);
		check_value("cold_xfers", 1, xfer_count);

		// other offsets in the same block, hit on both ways
		present(16'h123c, 16'h123a, 2'b11);
		check_value("repeat_hit", 3, int'(fetch_valid));
		repeat (3) @(negedge clock);
		check_value("repeat_cyc", 0, int'(wb_cyc));
		check_value("repeat_xfers", 1, xfer_count);

		// both ways miss together on different lines
		present(16'h2450, 16'h3468, 2'b11);
		check_value("share_miss", 0, int'(fetch_valid));
		wait_valid(2'b11);
		check_value("share_xfers", 3, xfer_count);

		// same index 7, new tag; way 1 watches the old line with fetch off
		present(16'h5638, 16'h1238, 2'b01);
		wait_valid(2'b01);
		check_value("evict_old", 0, int'(fetch_valid[1]));
		check_value("evict_xfers", 4, xfer_count);

		// ways swapped with fetch off, only the new tag hits
		present(16'h1238, 16'h5638, 2'b00);
		check_value("evict_swap", 2, int'(fetch_valid));

		// random lines, way 1 index kept apart from way 0
		repeat (8) begin
			r = $random(seed);
			present(r[15:0], {r[31:24], r[7:3] ^ 5'h10, r[18:16]}, 2'b11);
			wait_valid(2'b11);
		end

		repeat (4) @(negedge clock);
		if (dut0.props0.fail_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("%0d property violations at the end of the run", dut0.props0.fail_count);
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- flist.f
design/icache_pkg.sv
design/icache_mem.sv
design/miss_handler.sv
design/bus_arbiter.sv
design/icache_top.sv
bench/icache_props.sv
bench/icache_tb.sv

//--- Makefile
TOP = icache_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
